/* all.f */
+incdir+test
verilog/opl3_pkg.sv
verilog/reg_wr_if.sv
verilog/afifo.sv
verilog/host_if.sv
verilog/reg_file.sv
verilog/timers.sv
verilog/opl3_host_top.sv
test/tb_opl3_host.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the opl3 host testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal -f all.f --top-module tb_opl3_host -o tb_opl3_host
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_opl3_host > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0

/* test/tb_tasks.svh */
// ======================================================================
// testbench tasks for the opl3 host side
// host bus writes, read port and status polling, compare tasks
// and the directed tests
// ======================================================================

    task automatic check_reg(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_status(input reg_data_t got, input reg_data_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Fail o_dout: got %h, expected %h", got, exp));
    endtask

    task automatic host_idle(input int cycles);
        repeat (cycles) @(posedge clk_host);
        #10;
    endtask

    // wr low for hold host cycles and the model tracks the address/data rule
    task automatic host_write(input host_addr_t addr, input reg_data_t data, input int hold);
        @(posedge clk_host);
        #10;
        cs_n    = 1'b0;
        wr_n    = 1'b0;
        address = addr;
        din     = data;
        repeat (hold) begin
            @(posedge clk_host);
            #10;
            din = ~data;                          // only the first cycle may count
        end
        cs_n = 1'b1;
        wr_n = 1'b1;
        if (!addr[HOST_SEL_DATA]) begin
            lat_bank = addr[HOST_BANK];
            lat_addr = data;
        end else begin
            model[lat_bank][lat_addr] = data;
        end
    endtask

    task automatic write_reg(input bank_t bank, input reg_addr_t addr, input reg_data_t data);
        host_write({bank, 1'b0}, addr, 1);
        host_idle(WR_GAP);
        host_write({bank, 1'b1}, data, 1);
        host_idle(WR_GAP);
    endtask

    task automatic read_reg(input bank_t bank, input reg_addr_t addr, output reg_data_t data);
        @(posedge clk);
        #10;
        rd_bank = bank;
        rd_addr = addr;
        @(posedge clk);
        #10;
        data = rd_data;                           // one cycle read latency
    endtask

    task automatic wait_reg(input bank_t bank, input reg_addr_t addr);
        reg_data_t v;
        for (int i = 0; i < 32; i++) begin
            read_reg(bank, addr, v);
            if (v === model[bank][addr])
                break;
        end
        check_reg($sformatf("o_reg_rd_data[%0d][%h]", bank, addr), v, model[bank][addr]);
    endtask

    task automatic check_all_regs();
        reg_data_t v;
        for (int b = 0; b < 2; b++) begin
            for (int a = 0; a < 256; a++) begin
                read_reg(bank_t'(b), reg_addr_t'(a), v);
                check_reg($sformatf("o_reg_rd_data[%0d][%h]", b, a), v, model[b][a]);
            end
        end
    endtask

    task automatic wait_status(input reg_data_t exp, input int bound);
        for (int i = 0; i < bound; i++) begin
            if (dout === exp)
                break;
            @(posedge clk_host);
            #10;
        end
        check_status(dout, exp);
    endtask

    // stop both timers, then drop the flags
    task automatic stop_timers();
        write_reg(1'b0, TIMER_CTRL_REG, 8'h00);
        write_reg(1'b0, TIMER_CTRL_REG, reg_data_t'(1 << CTRL_IRQ_RST));
        wait_status(8'h00, 16);
    endtask

    task automatic bank_separation();
        write_reg(1'b0, 8'h40, 8'h5a);
        write_reg(1'b1, 8'h40, 8'ha5);            // same index in the other bank
        write_reg(1'b1, 8'hff, 8'h3c);
        wait_reg(1'b0, 8'h40);
        wait_reg(1'b1, 8'h40);
        wait_reg(1'b1, 8'hff);
        wait_reg(1'b0, 8'hff);                    // bank 0 copy untouched
    endtask

    task automatic addr_only_and_held_write();
        host_write(2'b00, 8'h41, 1);              // address only
        host_idle(WR_GAP);
        check_all_regs();
        host_write(2'b01, 8'h77, 5);              // data held five cycles
        host_idle(WR_GAP);
        write_reg(1'b0, 8'h42, 8'h88);
        wait_reg(1'b0, 8'h42);
        wait_reg(1'b0, 8'h41);
        check_all_regs();
    endtask

    task automatic timer1_overflow();
        write_reg(1'b0, TIMER1_REG, 8'hf0);       // 16 ticks to overflow
        host_write(2'b00, TIMER_CTRL_REG, 1);
        host_idle(WR_GAP);
        host_write(2'b01, reg_data_t'(1 << CTRL_ST_T1), 1);
        repeat (8 * TICK_CYCLES) begin
            @(posedge clk_host);
            #10;
            check_status(dout, 8'h00);
        end
        wait_status(reg_data_t'((1 << ST_IRQ) | (1 << ST_FT1)), 8 * TICK_CYCLES + 24);
    endtask

    task automatic timer2_irq_reset();
        reg_data_t preset;
        reg_data_t exp;
        int        period;
        int        bound;
        int        waited;
        preset = reg_data_t'($unsigned($random(seed)) % 192); // period well above irq reset latency
        exp    = reg_data_t'((1 << ST_IRQ) | (1 << ST_FT2));
        period = (256 - int'(preset)) * TIMER2_PRESCALE * TICK_CYCLES;
        bound  = period + 40;
        waited = 0;
        stop_timers();
        write_reg(1'b0, TIMER2_REG, preset);
        write_reg(1'b0, TIMER_CTRL_REG,
                  reg_data_t'((1 << CTRL_MASK_T1) | (1 << CTRL_ST_T2) | (1 << CTRL_ST_T1)));
        while (dout !== exp && waited < bound) begin
            check_status(dout, 8'h00);            // timer 1 is masked
            @(posedge clk_host);
            #10;
            waited++;
        end
        check_status(dout, exp);
        if (waited < period / 2)
            stop_on_error("timer 2 flag rose before half of its prescaled period");
        write_reg(1'b0, TIMER_CTRL_REG, reg_data_t'(1 << CTRL_IRQ_RST));
        wait_status(8'h00, 16);
    endtask

    task automatic masked_timers();
        reg_data_t masks;
        masks = reg_data_t'((1 << CTRL_MASK_T1) | (1 << CTRL_MASK_T2));
        stop_timers();
        write_reg(1'b0, TIMER1_REG, 8'hf0);
        write_reg(1'b0, TIMER2_REG, 8'hf0);
        write_reg(1'b0, TIMER_CTRL_REG, masks);
        write_reg(1'b0, TIMER_CTRL_REG, masks | reg_data_t'((1 << CTRL_ST_T2) | (1 << CTRL_ST_T1)));
        // timer 2 is slower with 16 counts of four ticks
        repeat (2 * 16 * TIMER2_PRESCALE * TICK_CYCLES) begin
            @(posedge clk_host);
            #10;
            check_status(dout, 8'h00);
        end
    endtask

    task automatic reset_clears_all();
        write_reg(1'b0, TIMER_CTRL_REG, reg_data_t'(1 << CTRL_ST_T1)); // timer 1 unmasked
        wait_status(reg_data_t'((1 << ST_IRQ) | (1 << ST_FT1)), 16 * TICK_CYCLES + 24);
        apply_reset();
        host_idle(4);                             // core status through both sync flops
        check_status(dout, 8'h00);
        check_all_regs();
    endtask

/* test/tb_opl3_host.sv */
// ======================================================================
// testbench for the opl3 host side
// two clocks and both resets, directed tests through the host bus
// and the register read port, bounded by a clk cycle counter
// ======================================================================
module tb_opl3_host;
    import opl3_pkg::*;

    localparam int TICK_CYCLES    = 4;
    localparam int WR_GAP         = 12;           // host cycles between writes keep the fifo shallow
    localparam int TIMEOUT_CYCLES = 40000;        // longest test about 4 x 4 x 256 x 4

    logic       clk;
    logic       reset;
    logic       clk_host;
    logic       reset_host;
    logic       cs_n;
    logic       wr_n;
    host_addr_t address;
    reg_data_t  din;
    reg_data_t  dout;
    bank_t      rd_bank;
    reg_addr_t  rd_addr;
    reg_data_t  rd_data;

    reg_data_t  model [2][256];                   // expected register contents
    bank_t      lat_bank;                         // set by the last address write
    reg_addr_t  lat_addr;
    int         cycle_cnt = 0;
    integer     seed = 32'hb2fb;

    opl3_host_top #(
        .FIFO_DEPTH_LOG2 (4),
        .TICK_CYCLES     (TICK_CYCLES)
    ) u_dut (
        .clk           (clk),
        .reset         (reset),
        .i_clk_host    (clk_host),
        .i_reset_host  (reset_host),
        .i_cs_n        (cs_n),
        .i_wr_n        (wr_n),
        .i_address     (address),
        .i_din         (din),
        .o_dout        (dout),
        .i_reg_rd_bank (rd_bank),
        .i_reg_rd_addr (rd_addr),
        .o_reg_rd_data (rd_data)
    );

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // both domains held for 3 of their own cycles
    task automatic apply_reset();
        reset      = 1'b1;
        reset_host = 1'b1;
        fork
            begin
                repeat (3) @(posedge clk);
                #10 reset = 1'b0;
            end
            begin
                repeat (3) @(posedge clk_host);
                #10 reset_host = 1'b0;
            end
        join
        lat_bank = '0;
        lat_addr = '0;
        for (int b = 0; b < 2; b++) begin
            for (int a = 0; a < 256; a++)
                model[b][a] = '0;                 // every register clears
        end
    endtask

    `include "tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        clk_host = 1'b0;
        #30;                                      // host clock lags by 30
        forever #50 clk_host = ~clk_host;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            stop_on_error($sformatf("timeout, run still busy after %0d clk cycles", cycle_cnt));
    end

    initial begin
        cs_n    = 1'b1;
        wr_n    = 1'b1;
        address = '0;
        din     = '0;
        rd_bank = '0;
        rd_addr = '0;
        apply_reset();
        bank_separation();
        addr_only_and_held_write();
        timer1_overflow();
        timer2_irq_reset();
        masked_timers();
        reset_clears_all();
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* verilog/opl3_host_top.sv */
// ======================================================================
// opl3 host side top level
// host bus and clock crossing, register file and timers
// joined through the register write channel
// ======================================================================
module opl3_host_top #(
    parameter int FIFO_DEPTH_LOG2 = 4,
    parameter int TICK_CYCLES     = 4             // clk cycles per base tick
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_clk_host,
    input  logic                 i_reset_host,
    input  logic                 i_cs_n,
    input  logic                 i_wr_n,
    input  opl3_pkg::host_addr_t i_address,
    input  opl3_pkg::reg_data_t  i_din,
    output opl3_pkg::reg_data_t  o_dout,
    input  opl3_pkg::bank_t      i_reg_rd_bank,
    input  opl3_pkg::reg_addr_t  i_reg_rd_addr,
    output opl3_pkg::reg_data_t  o_reg_rd_data
);
    import opl3_pkg::*;

    reg_data_t status;                            // timer flags to host

    reg_wr_if reg_wr ();

    host_if #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_host_if (
        .clk          (clk),
        .reset        (reset),
        .i_clk_host   (i_clk_host),
        .i_reset_host (i_reset_host),
        .i_cs_n       (i_cs_n),
        .i_wr_n       (i_wr_n),
        .i_address    (i_address),
        .i_din        (i_din),
        .o_dout       (o_dout),
        .i_status     (status),
        .reg_wr       (reg_wr.src)
    );

    reg_file u_reg_file (
        .clk           (clk),
        .reset         (reset),
        .reg_wr        (reg_wr.dst),
        .i_reg_rd_bank (i_reg_rd_bank),
        .i_reg_rd_addr (i_reg_rd_addr),
        .o_reg_rd_data (o_reg_rd_data)
    );

    timers #(
        .TICK_CYCLES (TICK_CYCLES)
    ) u_timers (
        .clk      (clk),
        .reset    (reset),
        .reg_wr   (reg_wr.dst),
        .o_status (status)
    );

endmodule

/* verilog/timers.sv */
// ======================================================================
// opl3 timers
// timer 1 steps on every base tick, timer 2 on every fourth
// overflow reloads the preset and sets the flag unless masked
// the flags make up the status byte
// ======================================================================
module timers #(
    parameter int TICK_CYCLES = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    reg_wr_if.dst                reg_wr,
    output opl3_pkg::reg_data_t  o_status
);
    import opl3_pkg::*;

    localparam int TICK_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;
    localparam int PRE_W  = $clog2(TIMER2_PRESCALE);

    logic [TICK_W-1:0] tick_cnt;
    logic              tick;                      // base tick strobe
    logic [PRE_W-1:0]  prescale_cnt;
    logic              wr_bank0;
    logic              ctrl_wr;
    logic [1:0]        preset_wr;                 // index 0 timer 1, 1 timer 2
    logic [1:0]        start_wr;
    logic [1:0]        mask_wr;
    logic [1:0]        step;                      // count enable per timer
    logic [1:0]        start;
    logic [1:0]        mask;
    logic [1:0]        flag;
    reg_data_t         preset [2];
    reg_data_t         count  [2];

    // base tick and timer 2 prescaler
    assign tick = tick_cnt == TICK_W'(TICK_CYCLES - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            tick_cnt     <= '0;
            prescale_cnt <= '0;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            if (tick)
                prescale_cnt <= prescale_cnt + 1'b1; // wraps at four
        end
    end

    assign step[0] = tick;
    assign step[1] = tick && prescale_cnt == PRE_W'(TIMER2_PRESCALE - 1);

    // bank 0 register decode
    assign wr_bank0     = reg_wr.valid && reg_wr.bank == 1'b0;
    assign preset_wr[0] = wr_bank0 && reg_wr.address == TIMER1_REG;
    assign preset_wr[1] = wr_bank0 && reg_wr.address == TIMER2_REG;
    assign ctrl_wr      = wr_bank0 && reg_wr.address == TIMER_CTRL_REG;
    assign start_wr     = {reg_wr.data[CTRL_ST_T2], reg_wr.data[CTRL_ST_T1]};
    assign mask_wr      = {reg_wr.data[CTRL_MASK_T2], reg_wr.data[CTRL_MASK_T1]};

    always_ff @(posedge clk) begin
        if (reset) begin
            start <= '0;
            mask  <= '0;
            flag  <= '0;
            for (int i = 0; i < 2; i++) begin
                preset[i] <= '0;
                count[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (preset_wr[i])
                    preset[i] <= reg_wr.data;
                if (ctrl_wr && !reg_wr.data[CTRL_IRQ_RST] && start_wr[i] && !start[i]) begin
                    count[i] <= preset[i];        // start loads the preset
                end else if (start[i] && step[i]) begin
                    if (count[i] == '1) begin
                        count[i] <= preset[i];    // overflow, reload
                        if (!mask[i])
                            flag[i] <= 1'b1;
                    end else begin
                        count[i] <= count[i] + 1'b1;
                    end
                end
            end
            if (ctrl_wr) begin
                if (reg_wr.data[CTRL_IRQ_RST]) begin
                    flag <= '0;                   // irq reset wins over overflow
                end else begin
                    start <= start_wr;
                    mask  <= mask_wr;
                end
            end
        end
    end

    // status byte
    always_comb begin
        o_status         = '0;
        o_status[ST_IRQ] = |flag;
        o_status[ST_FT1] = flag[0];
        o_status[ST_FT2] = flag[1];
    end

endmodule

/* verilog/reg_file.sv */
// ======================================================================
// register file
// two banks of 256 bytes written by the register write strobe,
// one registered read port for the sound engine
// ======================================================================
module reg_file (
    input  logic                 clk,
    input  logic                 reset,
    reg_wr_if.dst                reg_wr,
    input  opl3_pkg::bank_t      i_reg_rd_bank,
    input  opl3_pkg::reg_addr_t  i_reg_rd_addr,
    output opl3_pkg::reg_data_t  o_reg_rd_data
);
    import opl3_pkg::*;

    localparam int NUM_BANKS = 1 << $bits(bank_t);
    localparam int BANK_SIZE = 1 << $bits(reg_addr_t);

    reg_data_t regs [NUM_BANKS][BANK_SIZE];

    // write port
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int a = 0; a < BANK_SIZE; a++) begin
                    regs[b][a] <= '0;             // whole array cleared
                end
            end
        end else if (reg_wr.valid) begin
            regs[reg_wr.bank][reg_wr.address] <= reg_wr.data;
        end
    end

    // read port, one cycle latency
    always_ff @(posedge clk) begin
        if (reset)
            o_reg_rd_data <= '0;
        else
            o_reg_rd_data <= regs[i_reg_rd_bank][i_reg_rd_addr];
    end

endmodule

/* verilog/host_if.sv */
// ======================================================================
// host bus interface
// edge-detects host writes, moves them to the core clock through
// a dual-clock fifo and turns address/data pairs into register
// write strobes, status goes back through per-bit synchronizers
// ======================================================================
module host_if #(
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  i_clk_host,
    input  logic                  i_reset_host,
    input  logic                  i_cs_n,
    input  logic                  i_wr_n,
    input  opl3_pkg::host_addr_t  i_address,
    input  opl3_pkg::reg_data_t   i_din,
    output opl3_pkg::reg_data_t   o_dout,
    input  opl3_pkg::reg_data_t   i_status,
    reg_wr_if.src                 reg_wr
);
    import opl3_pkg::*;

    localparam int FIFO_WIDTH = $bits(host_addr_t) + $bits(reg_data_t);

    logic                  host_wr;               // write held on the bus
    logic                  host_wr_d;
    logic                  fifo_empty;
    logic [FIFO_WIDTH-1:0] pop_word;
    host_addr_t            pop_addr;
    reg_data_t             pop_data;
    reg_data_t             status_meta;

    // host clock domain
    assign host_wr = !i_cs_n && !i_wr_n;

    always_ff @(posedge i_clk_host) begin
        if (i_reset_host)
            host_wr_d <= 1'b0;
        else
            host_wr_d <= host_wr;                 // only first cycle of a held write
    end

    afifo #(
        .WIDTH      (FIFO_WIDTH),
        .DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_afifo (
        .i_wclk     (i_clk_host),
        .i_wr_reset (i_reset_host),
        .i_wr       (host_wr && !host_wr_d),
        .i_wr_data  ({i_address, i_din}),         // address and data as one word
        .o_wr_full  (),                           // host paces its writes
        .i_rclk     (clk),
        .i_rd_reset (reset),
        .i_rd       (!fifo_empty),                // pop one per cycle
        .o_rd_data  (pop_word),
        .o_rd_empty (fifo_empty)
    );

    // core clock domain
    assign {pop_addr, pop_data} = pop_word;

    always_ff @(posedge clk) begin
        if (reset)
            reg_wr.valid <= 1'b0;
        else
            reg_wr.valid <= !fifo_empty && pop_addr[HOST_SEL_DATA]; // data pop strobes
    end

    always_ff @(posedge clk) begin
        if (!fifo_empty) begin
            if (!pop_addr[HOST_SEL_DATA]) begin   // address entry
                reg_wr.bank    <= pop_addr[HOST_BANK];
                reg_wr.address <= pop_data;
            end else begin
                reg_wr.data    <= pop_data;       // bank/address kept from before
            end
        end
    end

    // status back to the host, bits may land a cycle apart
    always_ff @(posedge i_clk_host) begin
        if (i_reset_host) begin
            status_meta <= '0;
            o_dout      <= '0;
        end else begin
            status_meta <= i_status;
            o_dout      <= status_meta;
        end
    end

endmodule

/* verilog/afifo.sv */
// ======================================================================
// dual-clock fifo
// binary and gray pointers kept in each domain, the other side's
// gray pointer comes over through two flops
// read data falls through, full and empty are registered
// ======================================================================
module afifo #(
    parameter int WIDTH      = 10,
    parameter int DEPTH_LOG2 = 4
) (
    input  logic             i_wclk,
    input  logic             i_wr_reset,
    input  logic             i_wr,
    input  logic [WIDTH-1:0] i_wr_data,
    output logic             o_wr_full,
    input  logic             i_rclk,
    input  logic             i_rd_reset,
    input  logic             i_rd,
    output logic [WIDTH-1:0] o_rd_data,
    output logic             o_rd_empty
);
    localparam int DEPTH = 1 << DEPTH_LOG2;
    localparam int PW    = DEPTH_LOG2 + 1;       // extra wrap bit

    logic [WIDTH-1:0] mem [DEPTH];

    logic [PW-1:0] wbin, wgray, wbin_next, wgray_next;
    logic [PW-1:0] rbin, rgray, rbin_next, rgray_next;
    logic [PW-1:0] rgray_w1, rgray_w2;            // read pointer seen by writer
    logic [PW-1:0] wgray_r1, wgray_r2;            // write pointer seen by reader
    logic          full_next, empty_next;

    // write side
    always_comb begin
        wbin_next  = wbin + PW'(i_wr && !o_wr_full);      // drop writes when full
        wgray_next = (wbin_next >> 1) ^ wbin_next;
        // full when top two bits differ and the rest match
        full_next  = wgray_next == {~rgray_w2[PW-1 -: 2], rgray_w2[PW-3:0]};
    end

    always_ff @(posedge i_wclk) begin
        if (i_wr && !o_wr_full)
            mem[wbin[DEPTH_LOG2-1:0]] <= i_wr_data;
    end

    always_ff @(posedge i_wclk) begin
        if (i_wr_reset) begin
            wbin      <= '0;
            wgray     <= '0;
            rgray_w1  <= '0;
            rgray_w2  <= '0;
            o_wr_full <= 1'b0;
        end else begin
            wbin      <= wbin_next;
            wgray     <= wgray_next;
            rgray_w1  <= rgray;                   // first sync stage
            rgray_w2  <= rgray_w1;
            o_wr_full <= full_next;
        end
    end

    // read side
    always_comb begin
        rbin_next  = rbin + PW'(i_rd && !o_rd_empty);     // no pop when empty
        rgray_next = (rbin_next >> 1) ^ rbin_next;
        empty_next = rgray_next == wgray_r2;
    end

    always_ff @(posedge i_rclk) begin
        if (i_rd_reset) begin
            rbin       <= '0;
            rgray      <= '0;
            wgray_r1   <= '0;
            wgray_r2   <= '0;
            o_rd_empty <= 1'b1;
        end else begin
            rbin       <= rbin_next;
            rgray      <= rgray_next;
            wgray_r1   <= wgray;                  // first sync stage
            wgray_r2   <= wgray_r1;
            o_rd_empty <= empty_next;
        end
    end

    assign o_rd_data = mem[rbin[DEPTH_LOG2-1:0]]; // head of queue, fall-through

endmodule

/* verilog/reg_wr_if.sv */
// ======================================================================
// register write channel
// carries single-cycle write strobes from the host block
// to the register file and the timers
// ======================================================================
interface reg_wr_if;
    import opl3_pkg::*;

    logic      valid;    // one clk cycle per write
    bank_t     bank;     // stable while valid
    reg_addr_t address;
    reg_data_t data;

    // host side drives, consumers only look
    modport src (
        output valid,
        output bank,
        output address,
        output data
    );

    modport dst (
        input valid,
        input bank,
        input address,
        input data
    );

endinterface

/* verilog/opl3_pkg.sv */
// ======================================================================
// opl3 host side shared definitions
// widths of the data paths, timer register indices,
// control register bits and status byte layout
// ======================================================================
package opl3_pkg;

    localparam int REG_DATA_W  = 8;               // host data, register data, status
    localparam int REG_ADDR_W  = 8;               // index within one bank
    localparam int HOST_ADDR_W = 2;               // host bus address

    typedef logic [REG_DATA_W-1:0]  reg_data_t;
    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [HOST_ADDR_W-1:0] host_addr_t;
    typedef logic                   bank_t;

    // host bus address bits
    localparam int HOST_SEL_DATA = 0;             // 0 address write, 1 data write
    localparam int HOST_BANK     = 1;             // bank select

    // timer registers, bank 0
    localparam reg_addr_t TIMER1_REG     = 8'h02; // timer 1 preset
    localparam reg_addr_t TIMER2_REG     = 8'h03; // timer 2 preset
    localparam reg_addr_t TIMER_CTRL_REG = 8'h04; // flags reset, masks, start bits

    // control register bits
    localparam int CTRL_IRQ_RST = 7;              // clears both flags, nothing else
    localparam int CTRL_MASK_T1 = 6;
    localparam int CTRL_MASK_T2 = 5;
    localparam int CTRL_ST_T2   = 1;
    localparam int CTRL_ST_T1   = 0;

    // status byte, all other bits read 0
    localparam int ST_IRQ = 7;                    // or of both flags
    localparam int ST_FT1 = 6;
    localparam int ST_FT2 = 5;

    // timer 2 runs at a quarter of the base tick
    localparam int TIMER2_PRESCALE = 4;

endpackage
